// ==== rtl/dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Address and data word widths in bits
`define DCACHE_ADDR_W 32
`define DCACHE_WORD_W 32

// Words per line and burst length on the bus
`define DCACHE_LINE_WORDS 4

// Number of sets per way
`define DCACHE_SETS 16

// Associativity
`define DCACHE_WAYS 2

`endif

// ==== rtl/dcache_pkg.sv ====
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

    // Address field widths derived from the geometry
    localparam int BYTE_BITS   = $clog2(`DCACHE_WORD_W / 8);
    localparam int OFFSET_BITS = $clog2(`DCACHE_LINE_WORDS);
    localparam int INDEX_BITS  = $clog2(`DCACHE_SETS);
    localparam int TAG_BITS    = `DCACHE_ADDR_W - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

    typedef logic [`DCACHE_WORD_W-1:0]     word_t;
    typedef logic [`DCACHE_WORD_W/8-1:0]   be_t;
    typedef logic [`DCACHE_ADDR_W-1:0]     addr_t;
    typedef logic [INDEX_BITS-1:0]         index_t;
    typedef logic [TAG_BITS-1:0]           tag_t;
    typedef logic [OFFSET_BITS-1:0]        offset_t;
    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;
    typedef word_t [`DCACHE_LINE_WORDS-1:0] line_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE
    } req_op_t;

    typedef enum logic [2:0] {
        MS_IDLE,
        MS_WB_ADDR,
        MS_WB_DATA,
        MS_WB_RESP,
        MS_RF_ADDR,
        MS_RF_DATA,
        MS_FILL
    } miss_state_t;

    function automatic index_t addr_index(input addr_t a);
        return a[BYTE_BITS+OFFSET_BITS +: INDEX_BITS];
    endfunction

    function automatic tag_t addr_tag(input addr_t a);
        return a[`DCACHE_ADDR_W-1 -: TAG_BITS];
    endfunction

    function automatic offset_t addr_offset(input addr_t a);
        return a[BYTE_BITS +: OFFSET_BITS];
    endfunction

    // Line-aligned byte address from tag and set
    function automatic addr_t line_addr(input tag_t t, input index_t i);
        return {t, i, {(OFFSET_BITS + BYTE_BITS){1'b0}}};
    endfunction

endpackage

`default_nettype wire

// ==== rtl/dcache_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

// Held request plus the tag/data read of its set
interface lookup_if;
    import dcache_pkg::*;

    req_op_t op;
    addr_t   addr;
    word_t   wdata;
    be_t     be;

    logic hit;
    way_t hit_way;

    tag_entry_t [`DCACHE_WAYS-1:0] ways_tag;
    line_t      [`DCACHE_WAYS-1:0] ways_line;

    modport owner (
        output op, addr, wdata, be, hit, hit_way, ways_tag, ways_line
    );

    modport user (
        input op, addr, wdata, be, hit, hit_way, ways_tag, ways_line
    );
endinterface

// Single write port into the tag and data arrays
interface array_wr_if;
    import dcache_pkg::*;

    logic       we;
    way_t       way;
    index_t     index;
    tag_entry_t entry;
    line_t      line;

    modport writer (output we, way, index, entry, line);
    modport array  (input  we, way, index, entry, line);
endinterface

`default_nettype wire

// ==== rtl/dcache_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_lookup (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  read,
    input  logic                  write,
    input  dcache_pkg::addr_t     address,
    input  dcache_pkg::word_t     wrdata,
    input  dcache_pkg::be_t       byteenable,
    input  logic                  advance,
    lookup_if.owner               lk,
    array_wr_if.array             wr
);
    import dcache_pkg::*;

    tag_entry_t tag_mem  [`DCACHE_WAYS][`DCACHE_SETS];
    line_t      line_mem [`DCACHE_WAYS][`DCACHE_SETS];

    // Valid bits kept apart so only they need clearing
    logic [`DCACHE_WAYS-1:0][`DCACHE_SETS-1:0] valid_q;

    req_op_t                 req_op;
    index_t                  idx;
    tag_t                    req_tag;
    logic [`DCACHE_WAYS-1:0] hit_vec;

    // Write wins if both strobes are up
    always_comb begin
        if (write) begin
            req_op = OP_WRITE;
        end else if (read) begin
            req_op = OP_READ;
        end else begin
            req_op = OP_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lk.op <= OP_NONE;
        end else if (advance) begin
            lk.op <= req_op;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            lk.addr  <= address;
            lk.wdata <= wrdata;
            lk.be    <= byteenable;
        end
    end

    assign idx     = addr_index(lk.addr);
    assign req_tag = addr_tag(lk.addr);

    // Asynchronous read of the held set sees this cycle's array state
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            lk.ways_tag[w]       = tag_mem[w][idx];
            lk.ways_tag[w].valid = valid_q[w][idx];
            lk.ways_line[w]      = line_mem[w][idx];
            hit_vec[w]           = valid_q[w][idx] && (tag_mem[w][idx].tag == req_tag);
        end
    end

    always_comb begin
        lk.hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (hit_vec[w]) begin
                lk.hit_way = way_t'(w);
            end
        end
    end

    assign lk.hit = (lk.op != OP_NONE) && (|hit_vec);

    always_ff @(posedge clk) begin
        if (wr.we) begin
            tag_mem[wr.way][wr.index]  <= wr.entry;
            line_mem[wr.way][wr.index] <= wr.line;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr.we) begin
            valid_q[wr.way][wr.index] <= wr.entry.valid;
        end
    end

    // Refill must never duplicate a line already present in another way
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec))
        else $error("more than one way hits at set %0d", idx);

endmodule

`default_nettype wire

// ==== rtl/dcache_miss_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                advance,
    lookup_if.user              lk,
    output logic                fill_valid,
    output dcache_pkg::way_t    fill_way,
    output dcache_pkg::line_t   fill_line,
    output logic                aw_valid,
    input  logic                aw_ready,
    output dcache_pkg::addr_t   aw_addr,
    output logic                w_valid,
    input  logic                w_ready,
    output dcache_pkg::word_t   w_data,
    output logic                w_last,
    input  logic                b_valid,
    output logic                b_ready,
    output logic                ar_valid,
    input  logic                ar_ready,
    output dcache_pkg::addr_t   ar_addr,
    input  logic                r_valid,
    output logic                r_ready,
    input  dcache_pkg::word_t   r_data,
    input  logic                r_last
);
    import dcache_pkg::*;

    miss_state_t state_q;
    miss_state_t state_d;

    logic [7:0] lfsr_q;
    logic       lfsr_fb;
    way_t       victim;
    logic       victim_dirty;
    logic       miss;
    logic       start;

    offset_t beat_q;
    logic    last_beat;

    way_t  victim_q;
    addr_t wb_addr_q;
    line_t wb_line_q;
    line_t rf_line_q;

    assign miss  = (lk.op != OP_NONE) && !lk.hit;
    assign start = (state_q == MS_IDLE) && miss;

    // Taps 8,6,5,4 give a maximal length sequence
    assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
    assign victim  = lfsr_q[$bits(way_t)-1:0];
    assign victim_dirty = lk.ways_tag[victim].valid && lk.ways_tag[victim].dirty;

    // Line length is a power of two
    assign last_beat = &beat_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            MS_IDLE: begin
                if (miss) begin
                    state_d = victim_dirty ? MS_WB_ADDR : MS_RF_ADDR;
                end
            end
            MS_WB_ADDR: begin
                if (aw_ready) begin
                    state_d = MS_WB_DATA;
                end
            end
            MS_WB_DATA: begin
                if (w_ready && last_beat) begin
                    state_d = MS_WB_RESP;
                end
            end
            MS_WB_RESP: begin
                if (b_valid) begin
                    state_d = MS_RF_ADDR;
                end
            end
            MS_RF_ADDR: begin
                if (ar_ready) begin
                    state_d = MS_RF_DATA;
                end
            end
            MS_RF_DATA: begin
                if (r_valid && r_last) begin
                    state_d = MS_FILL;
                end
            end
            MS_FILL: begin
                if (advance) begin
                    state_d = MS_IDLE;
                end
            end
            default: state_d = MS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= MS_IDLE;
            lfsr_q  <= 8'h01;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (start) begin
                lfsr_q <= {lfsr_q[6:0], lfsr_fb};
            end
            if ((aw_valid && aw_ready) || (ar_valid && ar_ready)) begin
                beat_q <= '0;
            end else if ((w_valid && w_ready) || (r_valid && r_ready)) begin
                beat_q <= beat_q + offset_t'(1);
            end
        end
    end

    // Victim captured at the miss since the set stays untouched until the fill
    always_ff @(posedge clk) begin
        if (start) begin
            victim_q  <= victim;
            wb_addr_q <= line_addr(lk.ways_tag[victim].tag, addr_index(lk.addr));
            wb_line_q <= lk.ways_line[victim];
        end
        if (r_valid && r_ready) begin
            rf_line_q[beat_q] <= r_data;
        end
    end

    assign aw_valid = (state_q == MS_WB_ADDR);
    assign aw_addr  = wb_addr_q;
    assign w_valid  = (state_q == MS_WB_DATA);
    assign w_data   = wb_line_q[beat_q];
    assign w_last   = w_valid && last_beat;
    assign b_ready  = 1'b1;

    assign ar_valid = (state_q == MS_RF_ADDR);
    assign ar_addr  = line_addr(addr_tag(lk.addr), addr_index(lk.addr));
    assign r_ready  = (state_q == MS_RF_DATA);

    assign fill_valid = (state_q == MS_FILL);
    assign fill_way   = victim_q;
    assign fill_line  = rf_line_q;

    // Refill request holds its address until the slave takes it
    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar_addr)))
        else $error("ar_addr changed while waiting for ar_ready");

    // Slave must end the refill burst exactly on the last beat
    a_rlast_beat: assert property (@(posedge clk) disable iff (rst)
        (r_valid && r_ready) |-> (r_last == last_beat))
        else $error("r_last on beat %0d", beat_q);

endmodule

`default_nettype wire

// ==== rtl/dcache_update.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_update (
    input  logic                clk,
    input  logic                rst,
    input  logic                fill_valid,
    input  dcache_pkg::way_t    fill_way,
    input  dcache_pkg::line_t   fill_line,
    lookup_if.user              lk,
    array_wr_if.writer          wr,
    output logic                advance,
    output logic                stall,
    output logic                resp_valid,
    output dcache_pkg::word_t   rddata
);
    import dcache_pkg::*;

    line_t   src_line;
    line_t   new_line;
    offset_t off;
    word_t   old_word;
    word_t   merged_word;
    logic    is_write;
    logic    has_req;

    assign has_req  = (lk.op != OP_NONE);
    assign is_write = (lk.op == OP_WRITE);
    assign off      = addr_offset(lk.addr);

    // Hit way on a hit, otherwise the freshly collected refill line
    assign src_line = lk.hit ? lk.ways_line[lk.hit_way] : fill_line;
    assign old_word = src_line[off];

    always_comb begin
        for (int b = 0; b < $bits(be_t); b++) begin
            merged_word[8*b +: 8] = lk.be[b] ? lk.wdata[8*b +: 8] : old_word[8*b +: 8];
        end
    end

    always_comb begin
        new_line = src_line;
        if (is_write) begin
            new_line[off] = merged_word;
        end
    end

    assign stall   = has_req && !lk.hit && !fill_valid;
    assign advance = !stall;

    // Write hits dirty the line; fills are dirty only for a store miss
    assign wr.we    = (is_write && lk.hit) || fill_valid;
    assign wr.way   = lk.hit ? lk.hit_way : fill_way;
    assign wr.index = addr_index(lk.addr);
    assign wr.entry = '{valid: 1'b1, dirty: is_write, tag: addr_tag(lk.addr)};
    assign wr.line  = new_line;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= advance && has_req;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && (lk.op == OP_READ)) begin
            rddata <= old_word;
        end
    end

    // A refill is only started for a request that missed
    a_no_fill_on_hit: assert property (@(posedge clk) disable iff (rst)
        fill_valid |-> !lk.hit)
        else $error("fill_valid while the held request hits");

endmodule

`default_nettype wire

// ==== rtl/dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache (
    input  logic                clk,
    input  logic                rst,
    // CPU data port
    input  logic                read,
    input  logic                write,
    input  dcache_pkg::addr_t   address,
    input  dcache_pkg::word_t   wrdata,
    input  dcache_pkg::be_t     byteenable,
    output logic                stall,
    output dcache_pkg::word_t   rddata,
    output logic                resp_valid,
    // Write-back channels
    output logic                aw_valid,
    input  logic                aw_ready,
    output dcache_pkg::addr_t   aw_addr,
    output logic                w_valid,
    input  logic                w_ready,
    output dcache_pkg::word_t   w_data,
    output logic                w_last,
    input  logic                b_valid,
    output logic                b_ready,
    // Refill channels
    output logic                ar_valid,
    input  logic                ar_ready,
    output dcache_pkg::addr_t   ar_addr,
    input  logic                r_valid,
    output logic                r_ready,
    input  dcache_pkg::word_t   r_data,
    input  logic                r_last
);
    import dcache_pkg::*;

    logic  advance;
    logic  fill_valid;
    way_t  fill_way;
    line_t fill_line;

    lookup_if   lk_if ();
    array_wr_if wr_if ();

    dcache_lookup u_lookup (
        .clk        (clk),
        .rst        (rst),
        .read       (read),
        .write      (write),
        .address    (address),
        .wrdata     (wrdata),
        .byteenable (byteenable),
        .advance    (advance),
        .lk         (lk_if.owner),
        .wr         (wr_if.array)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .lk         (lk_if.user),
        .fill_valid (fill_valid),
        .fill_way   (fill_way),
        .fill_line  (fill_line),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .aw_addr    (aw_addr),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .w_data     (w_data),
        .w_last     (w_last),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar_addr    (ar_addr),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .r_data     (r_data),
        .r_last     (r_last)
    );

    dcache_update u_update (
        .clk        (clk),
        .rst        (rst),
        .fill_valid (fill_valid),
        .fill_way   (fill_way),
        .fill_line  (fill_line),
        .lk         (lk_if.user),
        .wr         (wr_if.writer),
        .advance    (advance),
        .stall      (stall),
        .resp_valid (resp_valid),
        .rddata     (rddata)
    );

endmodule

`default_nettype wire

// ==== bench/axi_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module axi_mem_model (
    input  logic                clk,
    input  logic                rst,
    input  logic                aw_valid,
    output logic                aw_ready,
    input  dcache_pkg::addr_t   aw_addr,
    input  logic                w_valid,
    output logic                w_ready,
    input  dcache_pkg::word_t   w_data,
    output logic                b_valid,
    input  logic                b_ready,
    input  logic                ar_valid,
    output logic                ar_ready,
    input  dcache_pkg::addr_t   ar_addr,
    output logic                r_valid,
    input  logic                r_ready,
    output dcache_pkg::word_t   r_data,
    output logic                r_last
);
    import dcache_pkg::*;

    // 1 KB of word storage
    localparam int MEM_WORDS = 256;

    word_t mem [MEM_WORDS];

    function automatic int word_index(input addr_t a);
        return int'((a >> 2) % MEM_WORDS);
    endfunction

    // Random wait of 0 to 3 cycles
    task automatic idle_cycles();
        int gap;
        gap = $urandom_range(3);
        repeat (gap) @(negedge clk);
    endtask

    task automatic serve_write_burst();
        addr_t base;
        int    beat;
        idle_cycles();
        aw_ready = 1'b1;
        base = aw_addr;
        @(negedge clk);
        aw_ready = 1'b0;
        for (beat = 0; beat < `DCACHE_LINE_WORDS; beat++) begin
            idle_cycles();
            while (!w_valid) begin
                @(negedge clk);
            end
            w_ready = 1'b1;
            mem[word_index(base) + beat] = w_data;
            @(negedge clk);
            w_ready = 1'b0;
        end
        idle_cycles();
        b_valid = 1'b1;
        while (!b_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        b_valid = 1'b0;
    endtask

    task automatic serve_read_burst();
        addr_t base;
        int    beat;
        idle_cycles();
        ar_ready = 1'b1;
        base = ar_addr;
        @(negedge clk);
        ar_ready = 1'b0;
        for (beat = 0; beat < `DCACHE_LINE_WORDS; beat++) begin
            idle_cycles();
            r_valid = 1'b1;
            r_data  = mem[word_index(base) + beat];
            r_last  = (beat == `DCACHE_LINE_WORDS - 1);
            while (!r_ready) begin
                @(negedge clk);
            end
            @(negedge clk);
            r_valid = 1'b0;
            r_last  = 1'b0;
        end
    endtask

    initial begin
        int i;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        r_last   = 1'b0;
        // Each word starts as its word address XOR a fixed pattern
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = word_t'(i) ^ 32'hA5A5A5A5;
        end
        forever begin
            @(negedge clk);
            if (!rst && aw_valid) begin
                serve_write_burst();
            end else if (!rst && ar_valid) begin
                serve_read_burst();
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int    RESET_CYCLES = 16;
    localparam int    MEM_WORDS    = 256;
    localparam int    LINE_BYTES   = `DCACHE_LINE_WORDS * `DCACHE_WORD_W / 8;
    localparam int    RAND_REQS    = 2000;
    // Directed requests plus the random run
    localparam int    TOTAL_REQS   = 4 + 16 + 24 + RAND_REQS;
    localparam int    CYCLE_LIMIT  = TOTAL_REQS * 60 + RESET_CYCLES;
    localparam word_t INIT_XOR     = 32'hA5A5A5A5;

    logic  clk;
    logic  rst;
    logic  read;
    logic  write;
    addr_t address;
    word_t wrdata;
    be_t   byteenable;
    logic  stall;
    word_t rddata;
    logic  resp_valid;
    logic  aw_valid;
    logic  aw_ready;
    addr_t aw_addr;
    logic  w_valid;
    logic  w_ready;
    word_t w_data;
    logic  w_last;
    logic  b_valid;
    logic  b_ready;
    logic  ar_valid;
    logic  ar_ready;
    addr_t ar_addr;
    logic  r_valid;
    logic  r_ready;
    word_t r_data;
    logic  r_last;

    // Reference memory with the slave's start pattern
    word_t ref_mem [MEM_WORDS];

    // Outstanding requests, oldest first
    logic  exp_read [$];
    word_t exp_data [$];
    addr_t exp_addr [$];

    int    errors       = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    cycle_count  = 0;
    int    resp_count   = 0;
    int    wb_count     = 0;
    int    wb_beat      = 0;
    addr_t wb_base      = '0;
    logic  mon_read;
    word_t mon_data;
    addr_t mon_addr;

    dcache DUT (.*);

    axi_mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: no progress within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic int word_index(input addr_t a);
        return int'((a >> 2) % MEM_WORDS);
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input be_t be);
        word_t w;
        int    b;
        w = old_w;
        for (b = 0; b < $bits(be_t); b++) begin
            if (be[b]) begin
                w[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return w;
    endfunction

    // Responses come back in acceptance order
    always @(posedge clk) begin
        if (!rst && resp_valid) begin
            resp_count++;
            if (exp_read.size() == 0) begin
                $display("Response pulse with no request outstanding at cycle %0d", cycle_count);
                errors++;
            end else begin
                mon_read = exp_read.pop_front();
                mon_data = exp_data.pop_front();
                mon_addr = exp_addr.pop_front();
                if (mon_read && rddata !== mon_data) begin
                    $display("MISMATCH rddata at %h: got %h, expected %h",
                             mon_addr, rddata, mon_data);
                    errors++;
                end
            end
        end
    end

    // Write-back and refill bursts on the bus
    always @(posedge clk) begin
        if (!rst) begin
            if (aw_valid && aw_ready) begin
                if (aw_addr % LINE_BYTES != 0) begin
                    $display("Write-back address %h is not line aligned", aw_addr);
                    errors++;
                end
                wb_base = aw_addr;
                wb_beat = 0;
                wb_count++;
            end
            if (w_valid && w_ready) begin
                if (wb_beat >= `DCACHE_LINE_WORDS) begin
                    $display("Write-back burst to %h has more than four beats", wb_base);
                    errors++;
                end else begin
                    if (w_data !== ref_mem[word_index(wb_base) + wb_beat]) begin
                        $display("MISMATCH w_data at %h beat %0d: got %h, expected %h", wb_base,
                                 wb_beat, w_data, ref_mem[word_index(wb_base) + wb_beat]);
                        errors++;
                    end
                    if (w_last !== (wb_beat == `DCACHE_LINE_WORDS - 1)) begin
                        $display("w_last is wrong on beat %0d of burst to %h", wb_beat, wb_base);
                        errors++;
                    end
                end
                wb_beat++;
            end
            if (b_valid && b_ready && wb_beat != `DCACHE_LINE_WORDS) begin
                $display("Write response after %0d data beats", wb_beat);
                errors++;
            end
            if (ar_valid && ar_ready && ar_addr % LINE_BYTES != 0) begin
                $display("Refill address %h is not line aligned", ar_addr);
                errors++;
            end
        end
    end

    // Called on a falling edge and returns on the falling edge after acceptance
    task automatic send_req(input logic is_wr, input addr_t a, input word_t d, input be_t be);
        read       = !is_wr;
        write      = is_wr;
        address    = a;
        wrdata     = d;
        byteenable = be;
        while (stall) begin
            @(negedge clk);
        end
        if (is_wr) begin
            ref_mem[word_index(a)] = merge_bytes(ref_mem[word_index(a)], d, be);
        end
        exp_read.push_back(!is_wr);
        exp_data.push_back(ref_mem[word_index(a)]);
        exp_addr.push_back(a);
        @(negedge clk);
        read  = 1'b0;
        write = 1'b0;
    endtask

    task automatic timed_read(input addr_t a, output int lat, output logic stalled);
        send_req(1'b0, a, '0, '0);
        lat     = 1;
        stalled = stall;
        while (!resp_valid) begin
            @(negedge clk);
            lat++;
        end
    endtask

    task automatic wait_idle();
        while (exp_read.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic expect_low(input string name, input logic v);
        if (v !== 1'b0) begin
            $display("MISMATCH %s: got %h, expected 0", name, v);
            errors++;
        end
    endtask

    task automatic close_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int    lat;
        logic  stalled;
        int    err0;
        int    resp0;
        int    wb0;
        int    i;
        int    t;
        addr_t a;

        void'($urandom(96202));
        rst        = 1'b1;
        read       = 1'b0;
        write      = 1'b0;
        address    = '0;
        wrdata     = '0;
        byteenable = '0;
        for (i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = word_t'(i) ^ INIT_XOR;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        err0 = errors;
        expect_low("stall", stall);
        expect_low("resp_valid", resp_valid);
        expect_low("aw_valid", aw_valid);
        expect_low("w_valid", w_valid);
        expect_low("ar_valid", ar_valid);
        expect_low("r_ready", r_ready);
        close_test("reset_state", err0);

        // Cold miss, then the rest of the line hits
        err0 = errors;
        timed_read(32'h100, lat, stalled);
        if (rddata !== ((word_t'(32'h100) >> 2) ^ INIT_XOR)) begin
            $display("MISMATCH rddata: got %h, expected %h", rddata,
                     (word_t'(32'h100) >> 2) ^ INIT_XOR);
            errors++;
        end
        for (i = 1; i < `DCACHE_LINE_WORDS; i++) begin
            a = 32'h100 + addr_t'(4 * i);
            timed_read(a, lat, stalled);
            if (stalled) begin
                $display("Hit read of %h stalled", a);
                errors++;
            end
            if (lat != 2) begin
                $display("Hit read of %h answered after %0d cycles instead of 2", a, lat);
                errors++;
            end
        end
        wait_idle();
        close_test("read_hit_latency", err0);

        err0 = errors;
        for (i = 0; i < 8; i++) begin
            a = addr_t'($urandom_range(MEM_WORDS - 1)) << 2;
            send_req(1'b1, a, $urandom, be_t'($urandom_range(15)));
            send_req(1'b0, a, '0, '0);
        end
        wait_idle();
        close_test("byte_enable_writes", err0);

        // Three dirty lines fighting over two ways of set 5
        err0 = errors;
        wb0  = wb_count;
        for (i = 0; i < 8; i++) begin
            for (t = 0; t < 3; t++) begin
                a = addr_t'(t * LINE_BYTES * `DCACHE_SETS + 5 * LINE_BYTES
                            + 4 * $urandom_range(`DCACHE_LINE_WORDS - 1));
                send_req(1'b1, a, $urandom, 4'hF);
            end
        end
        wait_idle();
        if (wb_count == wb0) begin
            $display("No write-back seen for conflicting dirty lines");
            errors++;
        end
        close_test("set_conflict_writeback", err0);

        err0  = errors;
        resp0 = resp_count;
        for (i = 0; i < RAND_REQS; i++) begin
            a = addr_t'($urandom_range(MEM_WORDS - 1)) << 2;
            send_req(1'($urandom_range(1)), a, $urandom, be_t'($urandom_range(15)));
        end
        wait_idle();
        if (resp_count - resp0 != RAND_REQS) begin
            $display("Expected %0d responses, saw %0d", RAND_REQS, resp_count - resp0);
            errors++;
        end
        close_test("random_traffic", err0);

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_ifs.sv
rtl/dcache_lookup.sv
rtl/dcache_miss_ctrl.sv
rtl/dcache_update.sv
rtl/dcache.sv
bench/axi_mem_model.sv
bench/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dcache_pkg.sv
      - rtl/dcache_ifs.sv
      - rtl/dcache_lookup.sv
      - rtl/dcache_miss_ctrl.sv
      - rtl/dcache_update.sv
      - rtl/dcache.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/axi_mem_model.sv
      - bench/dcache_tb.sv
